// File: logic/lsu_config.svh
// ==================================================
// Core widths and memory depth for the LSU
// Byte lanes and select logic assume 32-bit data
// ==================================================
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Data word width, four bytes per word
`define DATA_WIDTH 32

// Byte address width
`define ADDR_WIDTH 32

// Reorder buffer tag width
`define TAG_WIDTH 6

// Data memory depth in words, a power of two
`define DMEM_WORDS 256

`endif

// File: logic/lsu_types_pkg.sv
// ==================================================
// Core data, opcode and LSU op types
// ==================================================
`include "lsu_config.svh"
`default_nettype none

package lsu_types_pkg;

    typedef logic [`DATA_WIDTH-1:0] lsu_data_t;
    typedef logic [`ADDR_WIDTH-1:0] lsu_addr_t;
    typedef logic [`TAG_WIDTH-1:0]  lsu_tag_t;

    // RV32I major opcodes, only LOAD and STORE reach the LSU normally
    typedef enum logic [6:0] {
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_OPIMM  = 7'b0010011,
        OPCODE_OP     = 7'b0110011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011
    } lsu_opcode_t;

    typedef enum logic [2:0] {
        LSU_FUNC_LB,
        LSU_FUNC_LH,
        LSU_FUNC_LW,
        LSU_FUNC_LBU,
        LSU_FUNC_LHU,
        LSU_FUNC_SB,
        LSU_FUNC_SH,
        LSU_FUNC_SW
    } lsu_func_t;

    // Op as issued by the reservation station
    typedef struct packed {
        logic        valid;
        lsu_opcode_t opcode;
        lsu_data_t   insn;
        lsu_data_t   src_a;
        lsu_data_t   src_b;
        lsu_tag_t    tag;
    } lsu_issue_t;

    // Decoded op, data is the store value
    typedef struct packed {
        lsu_func_t func;
        lsu_addr_t addr;
        lsu_data_t data;
        lsu_tag_t  tag;
    } lsu_op_t;

    // Data is zero for store completions
    typedef struct packed {
        logic      valid;
        lsu_tag_t  tag;
        logic      is_store;
        lsu_data_t data;
    } lsu_result_t;

endpackage

`default_nettype wire

// File: logic/lsu_bus_pkg.sv
// ==================================================
// Wishbone classic request and response bundles
// Address is a byte address, sel has one bit per lane
// ==================================================
`default_nettype none

package lsu_bus_pkg;

    import lsu_types_pkg::*;

    // One select bit per byte lane
    typedef logic [3:0] wb_sel_t;

    // Master to slave
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        lsu_addr_t adr;
        lsu_data_t dat_w;
        wb_sel_t   sel;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic      ack;
        lsu_data_t dat_r;
    } wb_rsp_t;

endpackage

`default_nettype wire

// File: logic/lsu_id.sv
// ==================================================
// Access type decode and effective address
// Non-memory opcodes decode as LB
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module lsu_id
    import lsu_types_pkg::*;
(
    // From reservation station
    input  lsu_issue_t i_issue,

    // To execute stage
    output lsu_op_t    o_op,
    output logic       o_valid
);

    localparam int DW = $bits(lsu_data_t);

    lsu_func_t func;
    lsu_data_t imm_i;
    lsu_data_t imm_s;
    lsu_addr_t addr;
    logic      is_store;
    logic [2:0] funct3;

    assign funct3 = i_issue.insn[14:12];

    // Sign extended I and S immediates
    assign imm_i = {{(DW-11){i_issue.insn[31]}}, i_issue.insn[30:20]};
    assign imm_s = {{(DW-11){i_issue.insn[31]}}, i_issue.insn[30:25], i_issue.insn[11:7]};

    assign is_store = (i_issue.opcode == OPCODE_STORE);

    // Stores take the S immediate, everything else the I immediate
    assign addr = i_issue.src_a + (is_store ? imm_s : imm_i);

    always_comb begin
        case (i_issue.opcode)
            OPCODE_STORE: begin
                case (funct3)
                    3'b000:  func = LSU_FUNC_SB;
                    3'b001:  func = LSU_FUNC_SH;
                    default: func = LSU_FUNC_SW;
                endcase
            end
            OPCODE_LOAD: begin
                case (funct3)
                    3'b000:  func = LSU_FUNC_LB;
                    3'b001:  func = LSU_FUNC_LH;
                    3'b100:  func = LSU_FUNC_LBU;
                    3'b101:  func = LSU_FUNC_LHU;
                    // Reserved encodings fall back to a word load
                    default: func = LSU_FUNC_LW;
                endcase
            end
            default: func = LSU_FUNC_LB;
        endcase
    end

    always_comb begin
        o_op.func = func;
        o_op.addr = addr;
        o_op.data = i_issue.src_b;
        o_op.tag  = i_issue.tag;
    end

    assign o_valid = i_issue.valid;

endmodule

`default_nettype wire

// File: logic/lsu_ex.sv
// ==================================================
// Single-op Wishbone classic master for loads/stores
// Aligned accesses only, one transaction in flight
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module lsu_ex
    import lsu_types_pkg::*;
    import lsu_bus_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,

    // Decoded op from lsu_id
    input  lsu_op_t     i_op,
    input  logic        i_valid,
    output logic        o_ready,

    // Wishbone master port
    output wb_req_t     o_wb,
    input  wb_rsp_t     i_wb,

    // Result bus
    output lsu_result_t o_result
);

    localparam int DW = $bits(lsu_data_t);
    localparam int AW = $bits(lsu_addr_t);

    typedef enum logic [1:0] {
        IDLE,
        BUS,
        DONE
    } ex_state_t;

    ex_state_t   state;
    ex_state_t   state_next;
    lsu_op_t     op_q;
    lsu_data_t   load_data_q;
    lsu_data_t   load_data;
    lsu_data_t   dat_w;
    wb_sel_t     sel;
    logic        accept;
    logic        op_is_store;
    logic [1:0]  byte_off;
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;

    // Free again once the bus transaction has closed
    assign o_ready = (state == IDLE) || (state == DONE);
    assign accept  = i_valid && o_ready;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_next = BUS;
                end
            end
            BUS: begin
                if (i_wb.ack) begin
                    state_next = DONE;
                end
            end
            DONE: begin
                state_next = accept ? BUS : IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            op_q <= i_op;
        end
        // Read word is only valid with ack
        if ((state == BUS) && i_wb.ack) begin
            load_data_q <= load_data;
        end
    end

    assign op_is_store = op_q.func inside {LSU_FUNC_SB, LSU_FUNC_SH, LSU_FUNC_SW};
    assign byte_off    = op_q.addr[1:0];

    // Replicate store data across lanes, sel picks the live ones
    always_comb begin
        case (op_q.func)
            LSU_FUNC_SB, LSU_FUNC_LB, LSU_FUNC_LBU: begin
                sel   = 4'b0001 << byte_off;
                dat_w = {4{op_q.data[7:0]}};
            end
            LSU_FUNC_SH, LSU_FUNC_LH, LSU_FUNC_LHU: begin
                sel   = 4'b0011 << {byte_off[1], 1'b0};
                dat_w = {2{op_q.data[15:0]}};
            end
            default: begin
                sel   = 4'b1111;
                dat_w = op_q.data;
            end
        endcase
    end

    always_comb begin
        o_wb.cyc   = (state == BUS);
        o_wb.stb   = (state == BUS);
        o_wb.we    = op_is_store;
        o_wb.adr   = {op_q.addr[AW-1:2], 2'b00};
        o_wb.dat_w = dat_w;
        o_wb.sel   = sel;
    end

    // Pick the addressed byte or halfword out of the read word
    assign rd_byte = i_wb.dat_r[{byte_off, 3'b000} +: 8];
    assign rd_half = i_wb.dat_r[{byte_off[1], 4'b0000} +: 16];

    always_comb begin
        case (op_q.func)
            LSU_FUNC_LB:  load_data = {{(DW-8){rd_byte[7]}}, rd_byte};
            LSU_FUNC_LBU: load_data = {{(DW-8){1'b0}}, rd_byte};
            LSU_FUNC_LH:  load_data = {{(DW-16){rd_half[15]}}, rd_half};
            LSU_FUNC_LHU: load_data = {{(DW-16){1'b0}}, rd_half};
            LSU_FUNC_LW:  load_data = i_wb.dat_r;
            // Store completions report zero
            default:      load_data = '0;
        endcase
    end

    always_comb begin
        o_result.valid    = (state == DONE);
        o_result.tag      = op_q.tag;
        o_result.is_store = op_is_store;
        o_result.data     = load_data_q;
    end

endmodule

`default_nettype wire

// File: logic/lsu_dmem.sv
// ==================================================
// Wishbone classic data memory, one-cycle ack
// Word index wraps modulo DMEM_WORDS
// ==================================================
`include "lsu_config.svh"
`timescale 1ns/1ps
`default_nettype none

module lsu_dmem
    import lsu_types_pkg::*;
    import lsu_bus_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  wb_req_t i_wb,
    output wb_rsp_t o_wb
);

    localparam int IDX_W = $clog2(`DMEM_WORDS);
    localparam int LANES = $bits(wb_sel_t);

    lsu_data_t        mem [`DMEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             access;

    assign idx = i_wb.adr[2 +: IDX_W];

    // A new strobe is taken only while no ack is pending
    assign access = i_wb.cyc && i_wb.stb && !o_wb.ack;

    // Byte-enabled write
    always_ff @(posedge i_clk) begin
        if (access && i_wb.we) begin
            for (int b = 0; b < LANES; b++) begin
                if (i_wb.sel[b]) begin
                    mem[idx][b*8 +: 8] <= i_wb.dat_w[b*8 +: 8];
                end
            end
        end
    end

    // Read returns the word as it was before a same-cycle write
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_wb.ack   <= 1'b0;
            o_wb.dat_r <= '0;
        end else begin
            o_wb.ack <= access;
            if (access) begin
                o_wb.dat_r <= mem[idx];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/lsu_top.sv
// ==================================================
// LSU top with decode, execute and data memory
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module lsu_top
    import lsu_types_pkg::*;
    import lsu_bus_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,

    // Issue port from reservation station
    input  lsu_issue_t  i_issue,
    output logic        o_issue_ready,

    // Result bus
    output lsu_result_t o_result
);

    lsu_op_t id_op;
    logic    id_valid;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    lsu_id i_lsu_id (
        .i_issue (i_issue),
        .o_op    (id_op),
        .o_valid (id_valid)
    );

    lsu_ex i_lsu_ex (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_op     (id_op),
        .i_valid  (id_valid),
        .o_ready  (o_issue_ready),
        .o_wb     (wb_req),
        .i_wb     (wb_rsp),
        .o_result (o_result)
    );

    lsu_dmem i_lsu_dmem (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_wb    (wb_req),
        .o_wb    (wb_rsp)
    );

endmodule

`default_nettype wire

// File: tb/lsu_assert.sv
// ==================================================
// Wishbone classic and issue handshake properties
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module lsu_assert
    import lsu_types_pkg::*;
    import lsu_bus_pkg::*;
(
    input logic        i_clk,
    input logic        i_rst_n,
    input lsu_issue_t  i_issue,
    input logic        i_issue_ready,
    input wb_req_t     i_wb_req,
    input wb_rsp_t     i_wb_rsp,
    input lsu_result_t i_result
);

    stb_in_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb_req.stb |-> i_wb_req.cyc)
        else $error("Wishbone stb high without cyc");

    // Request stays put until the slave answers
    stb_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb_req.stb && !i_wb_rsp.ack |=> i_wb_req.stb && $stable(i_wb_req.adr)
            && $stable(i_wb_req.we) && $stable(i_wb_req.sel) && $stable(i_wb_req.dat_w))
        else $error("Wishbone request changed or dropped before ack");

    ack_with_stb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb_rsp.ack |-> i_wb_req.stb)
        else $error("Wishbone ack without stb");

    result_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_result.valid |=> !i_result.valid)
        else $error("Result valid longer than one cycle");

    // Every result follows an accepted op by three cycles
    result_after_issue: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_result.valid |-> $past(i_issue.valid && i_issue_ready, 3))
        else $error("Result valid without an op accepted three cycles earlier");

endmodule

bind lsu_top lsu_assert i_lsu_assert (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_issue       (i_issue),
    .i_issue_ready (o_issue_ready),
    .i_wb_req      (wb_req),
    .i_wb_rsp      (wb_rsp),
    .i_result      (o_result)
);

`default_nettype wire

// File: tb/lsu_tb.sv
// ==================================================
// Random LSU testbench with a byte-array memory model
// Only a 64-byte window is used, filled before any load
// ==================================================
`include "lsu_config.svh"
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
    import lsu_types_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 3;
    localparam int MEM_BYTES    = `DMEM_WORDS * 4;
    localparam int WIN_BASE     = 'h180;
    localparam int WIN_BYTES    = 64;
    localparam int MAX_IDLE     = 3;
    localparam int N_RANDOM     = 60;
    localparam int N_ADDR       = 24;
    localparam int N_BURST      = 24;
    localparam int TOTAL_OPS    = WIN_BYTES / 4 + 2 + N_RANDOM + N_ADDR + 8 + N_BURST;
    localparam int TIMEOUT_CYCLES = TOTAL_OPS * (4 + MAX_IDLE) + 200 + RESET_CYCLES;

    // Bit 3 is the store flag, bits 2:0 are funct3
    localparam logic [3:0] OP_KINDS [8] = '{4'b1000, 4'b1001, 4'b1010, 4'b0000,
                                            4'b0001, 4'b0010, 4'b0100, 4'b0101};
    // Reserved funct3 pairs, store then load
    localparam logic [2:0] BAD_ST [4] = '{3'b011, 3'b100, 3'b110, 3'b111};
    localparam logic [2:0] BAD_LD [4] = '{3'b110, 3'b011, 3'b111, 3'b110};

    logic        i_clk;
    logic        i_rst_n;
    lsu_issue_t  issue;
    logic        issue_ready;
    lsu_result_t result;

    logic [7:0]  model_mem [MEM_BYTES];
    lsu_result_t exp_q [$];
    int          exp_cyc_q [$];
    int          cycle_cnt = 0;
    int          err_cnt = 0;
    int          check_cnt = 0;
    int          test_cnt = 0;

    lsu_top i_lsu_top (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_issue       (issue),
        .o_issue_ready (issue_ready),
        .o_result      (result)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("Timeout after %0d cycles with %0d results still outstanding",
                 cycle_cnt, exp_q.size());
        $display("TESTS FAILED");
        $finish;
    end

    // Bytes per access from the RISC-V funct3 rules, reserved codes are words
    function automatic int access_size(input logic is_store, input logic [2:0] funct3);
        if (is_store) begin
            return (funct3 == 3'b000) ? 1 : ((funct3 == 3'b001) ? 2 : 4);
        end
        case (funct3)
            3'b000, 3'b100: return 1;
            3'b001, 3'b101: return 2;
            default:        return 4;
        endcase
    endfunction

    function automatic int mem_index(input lsu_addr_t addr);
        return int'(addr % lsu_addr_t'(MEM_BYTES));
    endfunction

    // Compare each result in order, sampled mid-cycle
    always @(negedge i_clk) begin : result_check
        lsu_result_t exp_res;
        int          exp_cyc;
        if (i_rst_n && result.valid) begin
            check_cnt++;
            if (exp_q.size() == 0) begin
                $display("Result with tag %h arrived with no op outstanding", result.tag);
                err_cnt++;
            end else begin
                exp_res = exp_q.pop_front();
                exp_cyc = exp_cyc_q.pop_front();
                if (result.tag !== exp_res.tag) begin
                    $display("FAILED o_result.tag: expected %h, got %h",
                             exp_res.tag, result.tag);
                    err_cnt++;
                end
                if (result.is_store !== exp_res.is_store) begin
                    $display("FAILED o_result.is_store tag %h: expected %h, got %h",
                             exp_res.tag, exp_res.is_store, result.is_store);
                    err_cnt++;
                end
                if (result.data !== exp_res.data) begin
                    $display("FAILED o_result.data tag %h: expected %h, got %h",
                             exp_res.tag, exp_res.data, result.data);
                    err_cnt++;
                end
                if (cycle_cnt != exp_cyc) begin
                    $display("Result for tag %h came in cycle %0d instead of cycle %0d",
                             exp_res.tag, cycle_cnt, exp_cyc);
                    err_cnt++;
                end
            end
        end
    end

    // Present one op, hold it until taken, and queue its predicted result
    task automatic issue_op(input logic is_store, input logic [2:0] funct3,
                            input lsu_addr_t base, input logic [11:0] imm,
                            input lsu_data_t wdata, input int idle);
        lsu_opcode_t opc;
        lsu_data_t   insn;
        lsu_addr_t   addr;
        lsu_result_t exp_res;
        lsu_data_t   ld;
        int          size;
        logic        uns;
        repeat (idle) begin
            @(posedge i_clk);
            #DRIVE_DELAY;
        end
        opc  = is_store ? OPCODE_STORE : OPCODE_LOAD;
        // The unused register fields are random so a wrong immediate shows up
        if (is_store) begin
            insn = {imm[11:5], 5'($urandom), 5'($urandom), funct3, imm[4:0], opc};
        end else begin
            insn = {imm, 5'($urandom), funct3, 5'($urandom), opc};
        end
        addr = base + {{20{imm[11]}}, imm};
        size = access_size(is_store, funct3);
        uns  = !is_store && funct3[2];
        exp_res.valid    = 1'b1;
        exp_res.tag      = 6'($urandom);
        exp_res.is_store = is_store;
        ld = '0;
        for (int i = 0; i < size; i++) begin
            if (is_store) begin
                model_mem[mem_index(addr + lsu_addr_t'(i))] = wdata[8*i +: 8];
            end else begin
                ld[8*i +: 8] = model_mem[mem_index(addr + lsu_addr_t'(i))];
            end
        end
        if (!uns && size == 1) begin
            ld[31:8] = {24{ld[7]}};
        end else if (!uns && size == 2) begin
            ld[31:16] = {16{ld[15]}};
        end
        exp_res.data = ld;
        issue.valid  = 1'b1;
        issue.opcode = opc;
        issue.insn   = insn;
        issue.src_a  = base;
        issue.src_b  = wdata;
        issue.tag    = exp_res.tag;
        while (!issue_ready) begin
            @(posedge i_clk);
            #DRIVE_DELAY;
        end
        exp_q.push_back(exp_res);
        exp_cyc_q.push_back(cycle_cnt + 3);
        @(posedge i_clk);
        #DRIVE_DELAY;
        issue.valid = 1'b0;
    endtask

    // Aligned access in the window, base either near it or above it
    task automatic issue_random(input logic [3:0] kind, input logic far_base, input int idle);
        lsu_addr_t   target;
        lsu_addr_t   base;
        logic [11:0] imm;
        int          size;
        size   = access_size(kind[3], kind[2:0]);
        target = lsu_addr_t'(WIN_BASE + ($urandom % (WIN_BYTES / size)) * size);
        if (far_base) begin
            base = lsu_addr_t'(WIN_BASE + WIN_BYTES) + lsu_addr_t'($urandom % 512);
            imm  = 12'(target - base);
        end else begin
            imm  = 12'($urandom % 128) - 12'd64;
            base = target - {{20{imm[11]}}, imm};
        end
        issue_op(kind[3], kind[2:0], base, imm, $urandom, idle);
    endtask

    task automatic wait_results();
        while (exp_q.size() != 0) begin
            @(posedge i_clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
        end
    endtask

    initial begin
        int        errs;
        lsu_addr_t addr_a;
        void'($urandom(45791));
        i_rst_n = 1'b0;
        issue   = '0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #DRIVE_DELAY;
        i_rst_n = 1'b1;

        errs = err_cnt;
        if (issue_ready !== 1'b1) begin
            $display("FAILED o_issue_ready: expected 1, got %h", issue_ready);
            err_cnt++;
        end
        if (result.valid !== 1'b0) begin
            $display("FAILED o_result.valid: expected 0, got %h", result.valid);
            err_cnt++;
        end
        for (int w = 0; w < WIN_BYTES / 4; w++) begin
            issue_op(1'b1, 3'b010, lsu_addr_t'(WIN_BASE + 4 * w), 12'd0, $urandom, 0);
            wait_results();
        end
        addr_a = lsu_addr_t'(WIN_BASE + 4 * ($urandom % (WIN_BYTES / 4)));
        issue_op(1'b1, 3'b010, addr_a, 12'd0, $urandom, 0);
        wait_results();
        issue_op(1'b0, 3'b010, addr_a, 12'd0, '0, 0);
        wait_results();
        report_test("reset and word store/load", errs);

        errs = err_cnt;
        for (int n = 0; n < N_RANDOM; n++) begin
            issue_random(OP_KINDS[3'($urandom)], 1'b0, int'($urandom % (MAX_IDLE + 1)));
            wait_results();
        end
        report_test("random sub-word stores and loads", errs);

        errs = err_cnt;
        for (int n = 0; n < N_ADDR; n++) begin
            issue_random(OP_KINDS[3'($urandom)], 1'b1, int'($urandom % (MAX_IDLE + 1)));
            wait_results();
        end
        report_test("negative immediates from a high base", errs);

        errs = err_cnt;
        for (int k = 0; k < 4; k++) begin
            addr_a = lsu_addr_t'(WIN_BASE + 4 * ($urandom % (WIN_BYTES / 4)));
            issue_op(1'b1, BAD_ST[k], addr_a, 12'd0, $urandom, 0);
            wait_results();
            issue_op(1'b0, BAD_LD[k], addr_a, 12'd0, '0, 0);
            wait_results();
        end
        report_test("reserved funct3 as word access", errs);

        // Back to back, each new op waits on a busy LSU
        errs = err_cnt;
        issue_random(OP_KINDS[3'($urandom)], 1'b0, 0);
        if (issue_ready !== 1'b0) begin
            $display("FAILED o_issue_ready: expected 0, got %h", issue_ready);
            err_cnt++;
        end
        for (int n = 1; n < N_BURST; n++) begin
            issue_random(OP_KINDS[3'($urandom)], n[0], 0);
        end
        wait_results();
        report_test("back-pressure and ordering", errs);

        $display("Summary: %0d tests, %0d results checked, %0d errors",
                 test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+logic
logic/lsu_types_pkg.sv
logic/lsu_bus_pkg.sv
logic/lsu_id.sv
logic/lsu_ex.sv
logic/lsu_dmem.sv
logic/lsu_top.sv
tb/lsu_assert.sv
tb/lsu_tb.sv

// File: run.sh
#!/bin/sh
# Build the LSU testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module lsu_tb -f list.f \
    && ./obj_dir/Vlsu_tb | tee sim.log
grep -qx "TESTS PASSED" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
